// ==== filelist.f ====
mac_pkg.sv
mult.sv
mac_cfg_regs.sv
mac_accum.sv
mac_unit_top.sv
mac_unit_assertions.sv
tb_mac_unit.sv

// ==== Makefile ====
# Verilator build for the vector MAC unit

VERILATOR    ?= verilator
TOP          ?= tb_mac_unit
FILELIST     ?= filelist.f
OBJ_DIR      ?= obj_dir
COMMON_FLAGS ?= --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   ?= --lint-only
BUILD_FLAGS  ?= --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

# A $fatal in the run gives a nonzero exit status
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mac_unit.sv ====
// Vector MAC unit testbench

`timescale 1ns/1ps

module tb_mac_unit;

  import mac_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Run parameters
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CLK_PERIOD_NS = 4;
  localparam int unsigned RESET_CYCLES  = 4;
  localparam int unsigned RAND_SEED     = 83;

  // Steps per test section
  localparam int unsigned READBACK_N = 16;
  localparam int unsigned PLAIN_N    = 8;
  localparam int unsigned SUB_N      = 4;
  localparam int unsigned ACC_N      = 24;
  localparam int unsigned CLEAR_N    = 8;
  localparam int unsigned FLAG_N     = 40;
  localparam int unsigned MIX_N      = 200;

  // Upper bound of clock cycles in the whole run
  localparam int unsigned RUN_CYCLES = RESET_CYCLES + READBACK_N + 4 * (PLAIN_N + 1)
                                     + 16 * (SUB_N + 1) + 4 * (ACC_N + 2) + CLEAR_N
                                     + FLAG_N + FLAG_N / 8 + 2 + MIX_N + 16;
  localparam int unsigned MARGIN_NS  = 200;

  // Model view of one operation
  typedef struct packed {
    logic [DATA_WIDTH-1:0] value;
    logic                  carry;
    logic                  overflow;
  } op_result_t;

  // DUT ports
  logic                  clk_i;
  logic                  arst_n_i;
  logic                  cfg_we_i;
  logic [DATA_WIDTH-1:0] cfg_wdata_i;
  logic [DATA_WIDTH-1:0] cfg_rdata_o;
  logic                  op_valid_i;
  logic [DATA_WIDTH-1:0] op_a_i;
  logic [DATA_WIDTH-1:0] op_b_i;
  logic                  acc_clear_i;
  logic [DATA_WIDTH-1:0] result_o;
  logic                  result_valid_o;
  mac_flags_t            flags_o;

  // Reference model state
  mac_cfg_t              m_cfg;
  logic [DATA_WIDTH-1:0] m_acc;
  logic [DATA_WIDTH-1:0] m_result;
  logic                  m_valid;
  mac_flags_t            m_flags;

  mac_unit_top i_dut
  (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_wdata_i    ( cfg_wdata_i    ),
    .cfg_rdata_o    ( cfg_rdata_o    ),
    .op_valid_i     ( op_valid_i     ),
    .op_a_i         ( op_a_i         ),
    .op_b_i         ( op_b_i         ),
    .acc_clear_i    ( acc_clear_i    ),
    .result_o       ( result_o       ),
    .result_valid_o ( result_valid_o ),
    .flags_o        ( flags_o        )
  );

  //////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end
  end

  // Twice the expected run length plus margin
  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD_NS * 2 + MARGIN_NS);
    $display("STATUS: FAIL");
    $display("watchdog expired before the test sequence finished");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Selected half with zero or sign fill
  function automatic logic [DATA_WIDTH-1:0] extend_half(logic [15:0] h, logic sgn);
    return {{16{sgn & h[15]}}, h};
  endfunction

  function automatic op_result_t expected_op(mac_cfg_t cfg, logic [DATA_WIDTH-1:0] acc,
                                             logic [DATA_WIDTH-1:0] a,
                                             logic [DATA_WIDTH-1:0] b, logic clr);
    op_result_t            r;
    logic [DATA_WIDTH-1:0] base_raw;
    logic [DATA_WIDTH-1:0] base;
    logic [DATA_WIDTH-1:0] ax;
    logic [DATA_WIDTH-1:0] bx;
    logic [DATA_WIDTH-1:0] prod;
    logic [DATA_WIDTH:0]   sum;
    // Clear forces a zero base and accumulate enable gates it
    base_raw = clr ? '0 : acc;
    base     = cfg.mac_en ? base_raw : '0;
    r        = '0;
    case (cfg.vector_mode)
      VEC_MODE16:
      begin
        for (int i = 0; i < 2; i++)
        begin
          r.value[16*i +: 16] = base[16*i +: 16] + a[16*i +: 16] * b[16*i +: 16];
        end
      end
      VEC_MODE8:
      begin
        for (int i = 0; i < 4; i++)
        begin
          r.value[8*i +: 8] = base[8*i +: 8] + a[8*i +: 8] * b[8*i +: 8];
        end
      end
      default:
      begin
        ax = a;
        bx = b;
        if (cfg.vector_mode == VEC_MODE216)
        begin
          ax = extend_half(cfg.sel_subword[1] ? a[31:16] : a[15:0], cfg.signed_mode[1]);
          bx = extend_half(cfg.sel_subword[0] ? b[31:16] : b[15:0], cfg.signed_mode[0]);
        end
        // Full-width add with carry out of bit 31
        prod    = ax * bx;
        sum     = {1'b0, base} + {1'b0, prod};
        r.value = sum[DATA_WIDTH-1:0];
        r.carry = sum[DATA_WIDTH];
      end
    endcase
    // Sign change against the accumulator base
    r.overflow = base_raw[DATA_WIDTH-1] ^ r.value[DATA_WIDTH-1];
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("STATUS: FAIL");
      $display("error %s expected %h got %h", name, expected, actual);
      $fatal(1, "output mismatch");
    end
  endtask

  // Drive one cycle, check last cycle's effect, then advance the model
  task automatic step(input logic we, input logic [DATA_WIDTH-1:0] wdata, input logic valid,
                      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                      input logic clr);
    op_result_t r;
    @(posedge clk_i);
    cfg_we_i    <= we;
    cfg_wdata_i <= wdata;
    op_valid_i  <= valid;
    op_a_i      <= a;
    op_b_i      <= b;
    acc_clear_i <= clr;
    // Outputs settled mid-cycle
    @(negedge clk_i);
    check_word("result_o", m_result, result_o);
    check_word("result_valid_o", 32'(m_valid), 32'(result_valid_o));
    check_word("flags_o", 32'(m_flags), 32'(flags_o));
    check_word("cfg_rdata_o", 32'(m_cfg), cfg_rdata_o);
    // Operation uses the configuration from before any write
    r       = expected_op(m_cfg, m_acc, a, b, clr);
    m_valid = valid;
    if (valid)
    begin
      m_acc    = r.value;
      m_result = r.value;
      if (clr)
      begin
        m_flags = '0;
      end
      m_flags.carry    = m_flags.carry | (m_cfg.mac_en & r.carry);
      m_flags.overflow = m_flags.overflow | (m_cfg.mac_en & r.overflow);
    end
    else if (clr)
    begin
      m_acc   = '0;
      m_flags = '0;
    end
    if (we)
    begin
      m_cfg = mac_cfg_t'(wdata[CFG_WIDTH-1:0]);
    end
  endtask

  // Upper data bits are random noise
  task automatic write_cfg(input vec_mode_e mode, input logic [1:0] sel,
                           input logic [1:0] sgn, input logic en);
    logic [DATA_WIDTH-1:0] wdata;
    wdata                  = $urandom;
    wdata[CFG_WIDTH-1:0]   = {mode, sel, sgn, en};
    step(1'b1, wdata, 1'b0, $urandom, $urandom, 1'b0);
  endtask

  task automatic issue_op(input logic clr);
    step(1'b0, $urandom, 1'b1, $urandom, $urandom, clr);
  endtask

  task automatic idle_cycle(input logic clr);
    step(1'b0, $urandom, 1'b0, $urandom, $urandom, clr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned pick;
    void'($urandom(RAND_SEED));
    arst_n_i    = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_wdata_i = '0;
    op_valid_i  = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    acc_clear_i = 1'b0;
    m_cfg       = '0;
    m_acc       = '0;
    m_result    = '0;
    m_valid     = 1'b0;
    m_flags     = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Configuration readback with random upper bits
    repeat (READBACK_N)
    begin
      step(1'b1, $urandom, 1'b0, $urandom, $urandom, 1'b0);
    end

    // Plain multiply in every mode
    for (int m = 0; m < 4; m++)
    begin
      write_cfg(vec_mode_e'(2'(m)), 2'($urandom), 2'($urandom), 1'b0);
      repeat (PLAIN_N) issue_op(1'b0);
    end

    // All subword and sign combinations
    for (int c = 0; c < 16; c++)
    begin
      write_cfg(VEC_MODE216, 2'(c >> 2), 2'(c), 1'b0);
      repeat (SUB_N) issue_op(1'b0);
    end

    // Accumulation with gaps and a fresh start per mode
    for (int m = 0; m < 4; m++)
    begin
      write_cfg(vec_mode_e'(2'(m)), 2'($urandom), 2'($urandom), 1'b1);
      issue_op(1'b1);
      repeat (ACC_N)
      begin
        if ($urandom % 3 == 0)
        begin
          idle_cycle(1'b0);
        end
        else
        begin
          issue_op(1'b0);
        end
      end
    end

    // Clear alone, then clear with an operation
    write_cfg(VEC_MODE32, 2'b00, 2'b00, 1'b1);
    issue_op(1'b0);
    issue_op(1'b0);
    idle_cycle(1'b1);
    idle_cycle(1'b0);
    issue_op(1'b0);
    issue_op(1'b1);
    idle_cycle(1'b0);

    // Sticky carry in 32-bit mode, then signed overflow in 216 mode
    write_cfg(VEC_MODE32, 2'b00, 2'b00, 1'b1);
    for (int n = 0; n < FLAG_N; n++)
    begin
      if (n == FLAG_N / 2)
      begin
        write_cfg(VEC_MODE216, 2'($urandom), 2'b11, 1'b1);
      end
      if (n % 8 == 7)
      begin
        idle_cycle(1'b1);
      end
      else
      begin
        issue_op(1'b0);
      end
    end

    // Random mix that includes write and operation in one cycle
    repeat (MIX_N)
    begin
      pick = $urandom % 8;
      case (pick)
        0:       write_cfg(vec_mode_e'(2'($urandom)), 2'($urandom), 2'($urandom),
                           1'($urandom));
        1:       step(1'b1, $urandom, 1'b1, $urandom, $urandom, 1'($urandom));
        2:       idle_cycle(1'b1);
        3:       idle_cycle(1'b0);
        4:       issue_op(1'b1);
        default: issue_op(1'b0);
      endcase
    end

    // Drain the last operation through the checks
    idle_cycle(1'b0);
    idle_cycle(1'b0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== mac_unit_assertions.sv ====
// MAC unit protocol assertions

`timescale 1ns/1ps

module mac_unit_assertions
(
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic                           op_valid_i,
  input logic                           acc_clear_i,
  input logic [mac_pkg::DATA_WIDTH-1:0] result_i,
  input logic                           result_valid_i,
  input mac_pkg::mac_flags_t            flags_i
);

  // Valid strobe is the operation strobe delayed by one cycle
  valid_follows_op: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    result_valid_i == $past(op_valid_i)
  ) else $error("result valid does not follow operation valid by one cycle");

  // Clear without an operation empties the flags
  flags_zero_after_clear: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ($past(acc_clear_i) && !$past(op_valid_i)) |-> (flags_i == '0)
  ) else $error("flags not zero after a clear without an operation");

  // First edge after reset release sees reset values
  outputs_zero_after_reset: assert property (
    @(posedge clk_i)
    $rose(arst_n_i) |-> (result_i == '0 && !result_valid_i && flags_i == '0)
  ) else $error("outputs not zero after reset");

endmodule

bind mac_unit_top mac_unit_assertions i_assertions
(
  .clk_i          ( clk_i          ),
  .arst_n_i       ( arst_n_i       ),
  .op_valid_i     ( op_valid_i     ),
  .acc_clear_i    ( acc_clear_i    ),
  .result_i       ( result_o       ),
  .result_valid_i ( result_valid_o ),
  .flags_i        ( flags_o        )
);

// ==== mac_unit_top.sv ====
// Vector MAC unit top level

`timescale 1ns/1ps

module mac_unit_top
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  // Configuration
  input  logic                           cfg_we_i,
  input  logic [mac_pkg::DATA_WIDTH-1:0] cfg_wdata_i,
  output logic [mac_pkg::DATA_WIDTH-1:0] cfg_rdata_o,

  // Operands
  input  logic                           op_valid_i,
  input  logic [mac_pkg::DATA_WIDTH-1:0] op_a_i,
  input  logic [mac_pkg::DATA_WIDTH-1:0] op_b_i,
  input  logic                           acc_clear_i,

  // Result
  output logic [mac_pkg::DATA_WIDTH-1:0] result_o,
  output logic                           result_valid_o,
  output mac_pkg::mac_flags_t            flags_o
);

  import mac_pkg::*;

  // Configuration to datapath
  mac_cfg_t cfg;

  // Accumulator loop
  logic [DATA_WIDTH-1:0] acc_base;
  logic [DATA_WIDTH-1:0] mul_result;
  logic                  mul_carry;
  logic                  mul_overflow;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  mac_cfg_regs i_cfg_regs
  (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_o       ( cfg         ),
    .cfg_rdata_o ( cfg_rdata_o )
  );

  // Plain words enter the union ports
  mult i_mult
  (
    .cfg_i      ( cfg          ),
    .op_a_i     ( op_a_i       ),
    .op_b_i     ( op_b_i       ),
    .mac_i      ( acc_base     ),
    .result_o   ( mul_result   ),
    .carry_o    ( mul_carry    ),
    .overflow_o ( mul_overflow )
  );

  mac_accum i_accum
  (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .op_valid_i     ( op_valid_i     ),
    .acc_clear_i    ( acc_clear_i    ),
    .mac_en_i       ( cfg.mac_en     ),
    .mul_result_i   ( mul_result     ),
    .mul_carry_i    ( mul_carry      ),
    .mul_overflow_i ( mul_overflow   ),
    .acc_base_o     ( acc_base       ),
    .result_o       ( result_o       ),
    .result_valid_o ( result_valid_o ),
    .flags_o        ( flags_o        )
  );

endmodule

// ==== mac_accum.sv ====
// MAC accumulator and sticky flags

`timescale 1ns/1ps

module mac_accum
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  // Control
  input  logic                           op_valid_i,
  input  logic                           acc_clear_i,
  input  logic                           mac_en_i,

  // From multiplier
  input  logic [mac_pkg::DATA_WIDTH-1:0] mul_result_i,
  input  logic                           mul_carry_i,
  input  logic                           mul_overflow_i,

  // To multiplier
  output logic [mac_pkg::DATA_WIDTH-1:0] acc_base_o,

  // Result and status
  output logic [mac_pkg::DATA_WIDTH-1:0] result_o,
  output logic                           result_valid_o,
  output mac_pkg::mac_flags_t            flags_o
);

  import mac_pkg::*;

  // Accumulator and shown result
  logic [DATA_WIDTH-1:0] acc_q;
  logic [DATA_WIDTH-1:0] result_q;
  logic                  valid_q;

  // Flag state
  mac_flags_t flags_q;
  mac_flags_t flags_base;
  mac_flags_t op_flags;

  //////////////////////////////////////////////////////////////////////
  // Accumulate base
  //////////////////////////////////////////////////////////////////////

  // A clear in the same cycle gives a zero base
  assign acc_base_o = acc_clear_i ? '0 : acc_q;
  assign flags_base = acc_clear_i ? '0 : flags_q;

  // Flags count only while accumulating
  assign op_flags.carry    = mac_en_i & mul_carry_i;
  assign op_flags.overflow = mac_en_i & mul_overflow_i;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      acc_q    <= '0;
      result_q <= '0;
      valid_q  <= 1'b0;
      flags_q  <= '0;
    end
    else
    begin
      // One-cycle strobe, fixed latency
      valid_q <= op_valid_i;

      if (op_valid_i)
      begin
        acc_q    <= mul_result_i;
        result_q <= mul_result_i;
        // Sticky, cleared first when a clear comes along
        flags_q  <= flags_base | op_flags;
      end
      else if (acc_clear_i)
      begin
        // Shown result holds until the next operation
        acc_q   <= '0;
        flags_q <= '0;
      end
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = valid_q;
  assign flags_o        = flags_q;

endmodule

// ==== mac_cfg_regs.sv ====
// MAC configuration register

`timescale 1ns/1ps

module mac_cfg_regs
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  // Write port
  input  logic                           cfg_we_i,
  input  logic [mac_pkg::DATA_WIDTH-1:0] cfg_wdata_i,

  // Datapath view and readback
  output mac_pkg::mac_cfg_t              cfg_o,
  output logic [mac_pkg::DATA_WIDTH-1:0] cfg_rdata_o
);

  import mac_pkg::*;

  // Stored configuration
  mac_cfg_t cfg_q;

  // Next value, built from the low data bits
  mac_cfg_t cfg_d;

  //////////////////////////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////////////////////////

  // Upper data bits have no storage behind them
  assign cfg_d = mac_cfg_t'(cfg_wdata_i[CFG_WIDTH-1:0]);

  // Reset gives 32-bit mode, unsigned, no accumulation
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cfg_q <= '0;
    end
    else if (cfg_we_i)
    begin
      cfg_q <= cfg_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////////////////////////

  // Datapath sees the register directly
  // An operation in the write cycle still uses the old value
  assign cfg_o = cfg_q;

  // Readback is zero-extended to word width
  assign cfg_rdata_o = {{(DATA_WIDTH-CFG_WIDTH){1'b0}}, cfg_q};

endmodule

// ==== mult.sv ====
// Vector multiplier
// Lane products with accumulate input

`timescale 1ns/1ps

module mult
(
  input  mac_pkg::mac_cfg_t              cfg_i,
  input  mac_pkg::mac_word_u             op_a_i,
  input  mac_pkg::mac_word_u             op_b_i,
  input  logic [mac_pkg::DATA_WIDTH-1:0] mac_i,
  output logic [mac_pkg::DATA_WIDTH-1:0] result_o,
  output logic                           carry_o,
  output logic                           overflow_o
);

  import mac_pkg::*;

  // Operands after subword selection
  mac_word_u op_a_sel;
  mac_word_u op_b_sel;

  // Accumulate base, zero when accumulation is off
  mac_word_u mac_int;

  // Lane-wise result
  mac_word_u result;

  // Full-width product and sum with carry bit
  logic [DATA_WIDTH-1:0] prod32;
  logic [DATA_WIDTH:0]   sum32;
  logic                  carry;

  //////////////////////////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    op_a_sel = op_a_i;
    op_b_sel = op_b_i;

    // Single 16x16 mode, pick a half and extend it
    if (cfg_i.vector_mode == VEC_MODE216)
    begin
      op_a_sel.h[0] = cfg_i.sel_subword[1] ? op_a_i.h[1] : op_a_i.h[0];
      op_b_sel.h[0] = cfg_i.sel_subword[0] ? op_b_i.h[1] : op_b_i.h[0];
      // Fill from the selected sign bit, or zero for unsigned
      op_a_sel.h[1] = {(DATA_WIDTH/NUM_HALVES){cfg_i.signed_mode[1] & op_a_sel.h[0][15]}};
      op_b_sel.h[1] = {(DATA_WIDTH/NUM_HALVES){cfg_i.signed_mode[0] & op_b_sel.h[0][15]}};
    end
  end

  assign mac_int.w32 = cfg_i.mac_en ? mac_i : '0;

  //////////////////////////////////////////////////////////////////////
  // Lane arithmetic
  //////////////////////////////////////////////////////////////////////

  // Product truncated to word width, carry comes from the add only
  assign prod32 = op_a_sel.w32 * op_b_sel.w32;
  assign sum32  = {1'b0, mac_int.w32} + {1'b0, prod32};

  always_comb
  begin
    result.w32 = sum32[DATA_WIDTH-1:0];
    carry      = 1'b0;

    case (cfg_i.vector_mode)
      VEC_MODE16:
      begin
        // Each half wraps inside its own lane
        for (int i = 0; i < NUM_HALVES; i++)
        begin
          result.h[i] = mac_int.h[i] + op_a_sel.h[i] * op_b_sel.h[i];
        end
      end

      VEC_MODE8:
      begin
        for (int i = 0; i < NUM_BYTES; i++)
        begin
          result.b[i] = mac_int.b[i] + op_a_sel.b[i] * op_b_sel.b[i];
        end
      end

      // VEC_MODE32 and VEC_MODE216 share the full-width sum
      default:
      begin
        carry = sum32[DATA_WIDTH];
      end
    endcase
  end

  assign result_o = result.w32;
  assign carry_o  = carry;

  // Sign change between base and result
  assign overflow_o = mac_i[DATA_WIDTH-1] ^ result.w32[DATA_WIDTH-1];

endmodule

// ==== mac_pkg.sv ====
// Vector MAC unit
// Shared types and constants

package mac_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int unsigned DATA_WIDTH = 32;

  // Used low bits of the configuration word
  localparam int unsigned CFG_WIDTH = 7;

  // Lane counts of the vector views
  localparam int unsigned NUM_HALVES = 2;
  localparam int unsigned NUM_BYTES  = 4;

  //////////////////////////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////////////////////////

  // Vector mode codes
  typedef enum logic [1:0] {
    // One full-width product
    VEC_MODE32  = 2'd0,
    // Two independent 16-bit lanes
    VEC_MODE16  = 2'd1,
    // Four independent 8-bit lanes
    VEC_MODE8   = 2'd2,
    // Selected 16-bit halves, extended to full width
    VEC_MODE216 = 2'd3
  } vec_mode_e;

  // Configuration word, MSB first
  // sel_subword[1] picks upper half of A, [0] upper half of B
  // signed_mode[1] sign-extends A, [0] sign-extends B
  typedef struct packed {
    vec_mode_e  vector_mode;
    logic [1:0] sel_subword;
    logic [1:0] signed_mode;
    logic       mac_en;
  } mac_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // Datapath views
  //////////////////////////////////////////////////////////////////////

  // Operand word, decoded as one value or as lanes
  typedef union packed {
    logic [DATA_WIDTH-1:0]                          w32;
    logic [NUM_HALVES-1:0][DATA_WIDTH/NUM_HALVES-1:0] h;
    logic [NUM_BYTES-1:0][DATA_WIDTH/NUM_BYTES-1:0]   b;
  } mac_word_u;

  // Sticky status flags
  typedef struct packed {
    logic carry;
    logic overflow;
  } mac_flags_t;

endpackage
